/* flist.f */
rtl/secdp_pkg.sv
rtl/secdp_decode.sv
rtl/secdp_regfile_ecc.sv
rtl/secdp_execute.sv
rtl/secdp_result.sv
rtl/secdp_top.sv
test/secdp_props.sv
test/secdp_tb.sv

/* rtl/secdp_decode.sv */
// Decode stage holding one instruction, splitting its fields and interlocking against execute
module secdp_decode import secdp_pkg::*; #(
  parameter int REG_AW = 5
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              in_valid,
  input  logic [XLEN-1:0]   in_instr,
  output logic              in_ready,
  input  logic [REG_AW-1:0] ex_busy_rd,
  input  logic              ex_busy,
  input  logic              halt,
  output logic              dec_valid,
  output secdp_op_e         dec_op,
  output logic [REG_AW-1:0] dec_rd,
  output logic [REG_AW-1:0] dec_rs1,
  output logic [REG_AW-1:0] dec_rs2,
  output logic [XLEN-1:0]   dec_imm,
  output logic              dec_use_rs1,
  output logic              dec_use_rs2
);

  logic             slot_valid_q;
  logic [XLEN-1:0]  slot_instr_q;
  logic             run_q;
  logic [IMM_W-1:0] imm;
  logic             hazard;
  logic             issue;
  logic             accept;

  // Register fields feed the register file read ports straight from the slot
  assign dec_rd  = slot_instr_q[RD_LSB +: REG_AW];
  assign dec_rs1 = slot_instr_q[RS1_LSB +: REG_AW];
  assign dec_rs2 = slot_instr_q[RS2_LSB +: REG_AW];
  assign imm     = slot_instr_q[IMM_LSB +: IMM_W];

  // Opcode decode with source-use flags and the extended immediate
  // Encodings outside the enum are executed as ADD
  always_comb begin
    dec_op      = OP_ADD;
    dec_use_rs1 = 1'b1;
    dec_use_rs2 = 1'b1;
    dec_imm     = '0;
    case (slot_instr_q[OPC_LSB +: OPC_W])
      OP_SUB: dec_op = OP_SUB;
      OP_AND: dec_op = OP_AND;
      OP_OR:  dec_op = OP_OR;
      OP_XOR: dec_op = OP_XOR;
      OP_ADDI: begin
        dec_op      = OP_ADDI;
        dec_use_rs2 = 1'b0;
        dec_imm     = {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
      end
      OP_LUI: begin
        // LUI reads no register at all
        dec_op      = OP_LUI;
        dec_use_rs1 = 1'b0;
        dec_use_rs2 = 1'b0;
        dec_imm     = {imm, {(XLEN-IMM_W){1'b0}}};
      end
      default: dec_op = OP_ADD;
    endcase
  end

  // The instruction in execute has not written back yet, so a used source matching
  // its destination must wait one cycle
  assign hazard = ex_busy &&
                  ((dec_use_rs1 && (dec_rs1 == ex_busy_rd)) ||
                   (dec_use_rs2 && (dec_rs2 == ex_busy_rd)));

  // dec_valid is high only in the cycle the instruction moves into execute
  assign issue     = slot_valid_q && !hazard && !halt;
  assign dec_valid = issue;

  // Room in the slot, no alert, and at least one clock out of reset
  assign in_ready = run_q && !halt && (!slot_valid_q || issue);
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      slot_valid_q <= 1'b0;
      run_q        <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (accept) begin
        slot_valid_q <= 1'b1;
      end else if (issue) begin
        slot_valid_q <= 1'b0;
      end
    end
  end

  // Instruction payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      slot_instr_q <= in_instr;
    end
  end

endmodule

/* rtl/secdp_execute.sv */
// Execute stage capturing operands and their fault flags and computing the ALU result
module secdp_execute import secdp_pkg::*; #(
  parameter int REG_AW = 5
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // From decode
  input  logic              dec_valid,
  input  secdp_op_e         dec_op,
  input  logic [REG_AW-1:0] dec_rd,
  input  logic [REG_AW-1:0] dec_rs1,
  input  logic [REG_AW-1:0] dec_rs2,
  input  logic [XLEN-1:0]   dec_imm,
  input  logic              dec_use_rs1,
  input  logic              dec_use_rs2,
  // From the register file
  input  logic [XLEN-1:0]   rd1_data,
  input  logic [XLEN-1:0]   rd2_data,
  input  logic              rd1_fault,
  input  logic              rd2_fault,
  input  logic              halt,
  // Interlock report back to decode
  output logic              ex_busy,
  output logic [REG_AW-1:0] ex_busy_rd,
  // To result
  output logic              ex_valid,
  output logic [REG_AW-1:0] ex_rd,
  output logic [XLEN-1:0]   ex_result,
  output logic              ex_fault,
  output logic [REG_AW-1:0] ex_rs1,
  output logic [XLEN-1:0]   ex_rs1_data,
  output logic [REG_AW-1:0] ex_rs2,
  output logic [XLEN-1:0]   ex_rs2_data
);

  logic            ex_valid_q;
  secdp_op_e       op_q;
  logic [XLEN-1:0] opa_q;
  logic [XLEN-1:0] opb_q;
  logic            use_rs2_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ex_valid_q <= 1'b0;
    end else begin
      ex_valid_q <= dec_valid && !halt;
    end
  end

  // Operands and fault flags at issue
  // An unused port contributes neither its data nor its fault, and its record
  // entry shows address and data zero
  always_ff @(posedge clk_i) begin
    if (dec_valid) begin
      op_q      <= dec_op;
      ex_rd     <= dec_rd;
      use_rs2_q <= dec_use_rs2;
      ex_rs1    <= dec_use_rs1 ? dec_rs1 : '0;
      ex_rs2    <= dec_use_rs2 ? dec_rs2 : '0;
      opa_q     <= dec_use_rs1 ? rd1_data : '0;
      opb_q     <= dec_use_rs2 ? rd2_data : dec_imm;
      ex_fault  <= (dec_use_rs1 && rd1_fault) || (dec_use_rs2 && rd2_fault);
    end
  end

  // Once the alert is held nothing in execute may commit
  assign ex_valid = ex_valid_q && !halt;

  // Destination still pending write-back, register 0 never blocks
  assign ex_busy    = ex_valid && (ex_rd != '0);
  assign ex_busy_rd = ex_rd;

  // Record data of the sources
  assign ex_rs1_data = opa_q;
  assign ex_rs2_data = use_rs2_q ? opb_q : '0;

  // ALU, the immediate already sits in opb_q for ADDI and LUI
  always_comb begin
    case (op_q)
      OP_SUB:  ex_result = opa_q - opb_q;
      OP_AND:  ex_result = opa_q & opb_q;
      OP_OR:   ex_result = opa_q | opb_q;
      OP_XOR:  ex_result = opa_q ^ opb_q;
      OP_LUI:  ex_result = opb_q;
      default: ex_result = opa_q + opb_q;
    endcase
  end

endmodule

/* rtl/secdp_pkg.sv */
// SEC datapath package with opcodes, instruction fields, word widths and ECC functions
package secdp_pkg;

  // Data word, check bits and the stored word that holds both
  localparam int XLEN   = 32;
  localparam int ECC_W  = 6;
  localparam int WORD_W = XLEN + ECC_W;

  // Check bits are inverted by this constant so that zero data is not stored as all zeros
  localparam logic [ECC_W-1:0] ECC_ZERO_CHECK = 6'h2a;

  // Instruction field positions
  localparam int OPC_LSB = 28;
  localparam int OPC_W   = 4;
  localparam int RD_LSB  = 23;
  localparam int RS1_LSB = 18;
  localparam int RS2_LSB = 13;
  localparam int IMM_LSB = 0;
  localparam int IMM_W   = 12;

  // Opcodes in bits 31 to 28 of the instruction word
  typedef enum logic [OPC_W-1:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_XOR  = 4'h4,
    OP_ADDI = 4'h5,
    OP_LUI  = 4'h6
  } secdp_op_e;

  // Parity-check column of each data bit
  // All columns are distinct and have at least two bits set, so any one or two
  // flipped bits in the stored word leave a nonzero syndrome
  localparam logic [ECC_W-1:0] ECC_COL [XLEN] = '{
    6'h07, 6'h0b, 6'h0d, 6'h0e, 6'h13, 6'h15, 6'h16, 6'h19,
    6'h1a, 6'h1c, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2a, 6'h2c,
    6'h31, 6'h32, 6'h34, 6'h38, 6'h1f, 6'h2f, 6'h37, 6'h3b,
    6'h3d, 6'h3e, 6'h03, 6'h05, 6'h06, 6'h09, 6'h0a, 6'h0c
  };

  // Check bits of a data word, already XORed with the zero-word constant
  function automatic logic [ECC_W-1:0] secdp_ecc_encode(input logic [XLEN-1:0] data);
    logic [ECC_W-1:0] chk;
    chk = ECC_ZERO_CHECK;
    for (int i = 0; i < XLEN; i++) begin
      if (data[i]) begin
        chk = chk ^ ECC_COL[i];
      end
    end
    return chk;
  endfunction

  // A stored word is faulty if its syndrome is nonzero or if it is stuck at all zeros or all ones
  function automatic logic secdp_ecc_fault(input logic [WORD_W-1:0] word);
    logic [ECC_W-1:0] syndrome;
    syndrome = secdp_ecc_encode(word[XLEN-1:0]) ^ word[WORD_W-1:XLEN];
    return (syndrome != '0) || (word == '0) || (word == '1);
  endfunction

endpackage

/* rtl/secdp_regfile_ecc.sv */
// ECC-protected register file with two read ports, one write port and a glitch port
module secdp_regfile_ecc import secdp_pkg::*; #(
  parameter int NUM_REGS = 32,
  parameter int REG_AW   = 5
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Read ports
  input  logic [REG_AW-1:0] rd1_addr,
  input  logic [REG_AW-1:0] rd2_addr,
  output logic [XLEN-1:0]   rd1_data,
  output logic [XLEN-1:0]   rd2_data,
  output logic              rd1_fault,
  output logic              rd2_fault,
  // Write port
  input  logic              wr_en,
  input  logic [REG_AW-1:0] wr_addr,
  input  logic [XLEN-1:0]   wr_data,
  // Fault injection
  input  logic              glitch_valid,
  input  logic [REG_AW-1:0] glitch_addr,
  input  logic [WORD_W-1:0] glitch_mask
);

  // Stored form of the zero word
  localparam logic [WORD_W-1:0] ZERO_WORD = {ECC_ZERO_CHECK, {XLEN{1'b0}}};

  // Each entry keeps check bits in the upper ECC_W bits and data below
  logic [WORD_W-1:0] mem_q [NUM_REGS];

  logic [WORD_W-1:0] wr_word;
  logic              wr_hit;
  logic              glitch_hit;
  logic [WORD_W-1:0] rd1_word;
  logic [WORD_W-1:0] rd2_word;

  // Data is encoded on the way in
  assign wr_word = {secdp_ecc_encode(wr_data), wr_data};

  // A glitch on the same entry wins over the write in that cycle
  assign glitch_hit = glitch_valid && (glitch_addr == wr_addr);

  // Entry 0 is hardwired and never written
  assign wr_hit = wr_en && (wr_addr != '0) && !glitch_hit;

  // Every entry comes out of reset holding the encoded zero word
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        mem_q[i] <= ZERO_WORD;
      end
    end else begin
      if (wr_hit) begin
        mem_q[wr_addr] <= wr_word;
      end
      // The glitch flips stored bits without re-encoding them
      if (glitch_valid) begin
        mem_q[glitch_addr] <= mem_q[glitch_addr] ^ glitch_mask;
      end
    end
  end

  // Raw stored words on both ports
  assign rd1_word = mem_q[rd1_addr];
  assign rd2_word = mem_q[rd2_addr];

  // Port 1 check
  // Address 0 reads zero and never faults, whatever the entry holds
  assign rd1_data  = (rd1_addr == '0) ? '0 : rd1_word[XLEN-1:0];
  assign rd1_fault = (rd1_addr != '0) && secdp_ecc_fault(rd1_word);

  // Port 2 check, same rules as port 1
  assign rd2_data  = (rd2_addr == '0) ? '0 : rd2_word[XLEN-1:0];
  assign rd2_fault = (rd2_addr != '0) && secdp_ecc_fault(rd2_word);

endmodule

/* rtl/secdp_result.sv */
// Result stage with write-back, retirement record and the sticky major alert
module secdp_result import secdp_pkg::*; #(
  parameter int REG_AW = 5
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // From execute
  input  logic              ex_valid,
  input  logic [REG_AW-1:0] ex_rd,
  input  logic [XLEN-1:0]   ex_result,
  input  logic              ex_fault,
  input  logic [REG_AW-1:0] ex_rs1,
  input  logic [XLEN-1:0]   ex_rs1_data,
  input  logic [REG_AW-1:0] ex_rs2,
  input  logic [XLEN-1:0]   ex_rs2_data,
  // Register file write port
  output logic              wr_en,
  output logic [REG_AW-1:0] wr_addr,
  output logic [XLEN-1:0]   wr_data,
  // Retirement record
  output logic              retire_valid,
  output logic [REG_AW-1:0] retire_rd,
  output logic [XLEN-1:0]   retire_wdata,
  output logic [REG_AW-1:0] retire_rs1,
  output logic [XLEN-1:0]   retire_rs1_rdata,
  output logic [REG_AW-1:0] retire_rs2,
  output logic [XLEN-1:0]   retire_rs2_rdata,
  output logic              alert_major,
  output logic              halt
);

  logic commit;
  logic alert_q;

  // An instruction without a fault commits in the cycle it sits in execute
  assign commit = ex_valid && !ex_fault;

  // Register 0 is never written but its instruction still retires
  assign wr_en   = commit && (ex_rd != '0);
  assign wr_addr = ex_rd;
  assign wr_data = ex_result;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      retire_valid <= 1'b0;
      alert_q      <= 1'b0;
    end else begin
      retire_valid <= commit;
      // A faulting instruction raises the alert in place of its retirement
      if (ex_valid && ex_fault) begin
        alert_q <= 1'b1;
      end
    end
  end

  // Record payload, captured on the write-back edge
  always_ff @(posedge clk_i) begin
    if (commit) begin
      retire_rd        <= ex_rd;
      retire_wdata     <= ex_result;
      retire_rs1       <= ex_rs1;
      retire_rs1_rdata <= ex_rs1_data;
      retire_rs2       <= ex_rs2;
      retire_rs2_rdata <= ex_rs2_data;
    end
  end

  // The held alert is also the stop signal for decode and execute
  assign alert_major = alert_q;
  assign halt        = alert_q;

endmodule

/* rtl/secdp_top.sv */
// SEC datapath top level joining decode, register file, execute and result
module secdp_top import secdp_pkg::*; #(
  parameter int NUM_REGS = 32,
  localparam int REG_AW  = $clog2(NUM_REGS)
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Instruction stream
  input  logic              in_valid,
  input  logic [XLEN-1:0]   in_instr,
  output logic              in_ready,
  // Fault injection
  input  logic              glitch_valid,
  input  logic [REG_AW-1:0] glitch_addr,
  input  logic [WORD_W-1:0] glitch_mask,
  // Retirement record
  output logic              retire_valid,
  output logic [REG_AW-1:0] retire_rd,
  output logic [XLEN-1:0]   retire_wdata,
  output logic [REG_AW-1:0] retire_rs1,
  output logic [XLEN-1:0]   retire_rs1_rdata,
  output logic [REG_AW-1:0] retire_rs2,
  output logic [XLEN-1:0]   retire_rs2_rdata,
  output logic              alert_major
);

  // Decode to execute
  logic              dec_valid;
  secdp_op_e         dec_op;
  logic [REG_AW-1:0] dec_rd;
  logic [REG_AW-1:0] dec_rs1;
  logic [REG_AW-1:0] dec_rs2;
  logic [XLEN-1:0]   dec_imm;
  logic              dec_use_rs1;
  logic              dec_use_rs2;

  // Register file reads
  logic [XLEN-1:0]   rd1_data;
  logic [XLEN-1:0]   rd2_data;
  logic              rd1_fault;
  logic              rd2_fault;

  // Execute to result, and the interlock back to decode
  logic              ex_busy;
  logic [REG_AW-1:0] ex_busy_rd;
  logic              ex_valid;
  logic [REG_AW-1:0] ex_rd;
  logic [XLEN-1:0]   ex_result;
  logic              ex_fault;
  logic [REG_AW-1:0] ex_rs1;
  logic [XLEN-1:0]   ex_rs1_data;
  logic [REG_AW-1:0] ex_rs2;
  logic [XLEN-1:0]   ex_rs2_data;

  // Write-back and the stop signal
  logic              wr_en;
  logic [REG_AW-1:0] wr_addr;
  logic [XLEN-1:0]   wr_data;
  logic              halt;

  secdp_decode #(.REG_AW(REG_AW)) u_decode (
    .clk_i, .rst_ni, .in_valid, .in_instr, .in_ready,
    .ex_busy_rd, .ex_busy, .halt,
    .dec_valid, .dec_op, .dec_rd, .dec_rs1, .dec_rs2, .dec_imm, .dec_use_rs1, .dec_use_rs2
  );

  // Read addresses come straight from the decode slot
  secdp_regfile_ecc #(.NUM_REGS(NUM_REGS), .REG_AW(REG_AW)) u_regfile (
    .clk_i, .rst_ni,
    .rd1_addr(dec_rs1), .rd2_addr(dec_rs2),
    .rd1_data, .rd2_data, .rd1_fault, .rd2_fault,
    .wr_en, .wr_addr, .wr_data,
    .glitch_valid, .glitch_addr, .glitch_mask
  );

  secdp_execute #(.REG_AW(REG_AW)) u_execute (
    .clk_i, .rst_ni,
    .dec_valid, .dec_op, .dec_rd, .dec_rs1, .dec_rs2, .dec_imm, .dec_use_rs1, .dec_use_rs2,
    .rd1_data, .rd2_data, .rd1_fault, .rd2_fault, .halt,
    .ex_busy, .ex_busy_rd,
    .ex_valid, .ex_rd, .ex_result, .ex_fault,
    .ex_rs1, .ex_rs1_data, .ex_rs2, .ex_rs2_data
  );

  secdp_result #(.REG_AW(REG_AW)) u_result (
    .clk_i, .rst_ni,
    .ex_valid, .ex_rd, .ex_result, .ex_fault,
    .ex_rs1, .ex_rs1_data, .ex_rs2, .ex_rs2_data,
    .wr_en, .wr_addr, .wr_data,
    .retire_valid, .retire_rd, .retire_wdata,
    .retire_rs1, .retire_rs1_rdata, .retire_rs2, .retire_rs2_rdata,
    .alert_major, .halt
  );

endmodule

/* run.sh */
#!/bin/sh
# Builds the SEC datapath testbench with Verilator and runs it.
# The exit status is that of the simulation.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module secdp_tb \
  -Mdir obj_dir \
  -f flist.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vsecdp_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished"
exit 0

/* test/secdp_props.sv */
// Register file checks on reset contents, write encoding and stuck stored words
module secdp_props import secdp_pkg::*; #(
  parameter int NUM_REGS = 32,
  parameter int REG_AW   = 5
) (
  input logic              clk_i,
  input logic              rst_ni,
  input logic [WORD_W-1:0] mem_q [NUM_REGS],
  input logic              wr_en,
  input logic [REG_AW-1:0] wr_addr,
  input logic [XLEN-1:0]   wr_data,
  input logic              glitch_valid,
  input logic [REG_AW-1:0] glitch_addr
);
  timeunit 1ns;
  timeprecision 100ps;

  // Zero data with its check bits 2a
  localparam logic [WORD_W-1:0] ZERO_WORD = {ECC_ZERO_CHECK, {XLEN{1'b0}}};

  logic                all_reset;
  logic                stuck_word;
  logic [NUM_REGS-1:0] glitched_q;
  logic                wr_pending_q;
  logic [REG_AW-1:0]   wr_addr_q;
  logic [WORD_W-1:0]   wr_word_q;

  // Scan of all entries, glitched entries are allowed to hold anything
  always_comb begin
    all_reset  = 1'b1;
    stuck_word = 1'b0;
    for (int i = 0; i < NUM_REGS; i++) begin
      if (mem_q[i] != ZERO_WORD) begin
        all_reset = 1'b0;
      end
      if (!glitched_q[i] && ((mem_q[i] == '0) || (mem_q[i] == '1))) begin
        stuck_word = 1'b1;
      end
    end
  end

  // Remember each accepted write and which entries carry an injected glitch
  // A glitch on the written entry wins, as in the register file
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      glitched_q   <= '0;
      wr_pending_q <= 1'b0;
    end else begin
      wr_pending_q <= wr_en && (wr_addr != '0) && !(glitch_valid && (glitch_addr == wr_addr));
      wr_addr_q    <= wr_addr;
      wr_word_q    <= {secdp_ecc_encode(wr_data), wr_data};
      if (wr_en && (wr_addr != '0)) begin
        glitched_q[wr_addr] <= 1'b0;
      end
      if (glitch_valid) begin
        glitched_q[glitch_addr] <= 1'b1;
      end
    end
  end

  a_reset_contents: assert property (@(posedge clk_i) $rose(rst_ni) |-> all_reset)
    else $error("Register file entry differs from the encoded zero word after reset");

  a_write_encoding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_pending_q |-> (mem_q[wr_addr_q] == wr_word_q))
    else $error("Written entry does not hold the data with its check bits");

  a_no_stuck_word: assert property (@(posedge clk_i) disable iff (!rst_ni) !stuck_word)
    else $error("Unglitched register file entry is all zeros or all ones");

endmodule

bind secdp_regfile_ecc secdp_props #(
  .NUM_REGS(NUM_REGS),
  .REG_AW(REG_AW)
) u_props (
  .clk_i(clk_i),
  .rst_ni(rst_ni),
  .mem_q(mem_q),
  .wr_en(wr_en),
  .wr_addr(wr_addr),
  .wr_data(wr_data),
  .glitch_valid(glitch_valid),
  .glitch_addr(glitch_addr)
);

/* test/secdp_tb.sv */
// Testbench for the SEC datapath with LCG stimulus, a reference model and fault injection
module secdp_tb import secdp_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_REGS   = 32;
  localparam int REG_AW     = 5;
  localparam int RST_CYCLES = 5;
  localparam int N_SWEEP    = 32;
  localparam int N_RAND     = 300;
  localparam int N_RAND2    = 100;
  // Two sweeps, two random runs and a handful of directed instructions
  localparam int TOTAL_INSTR     = 2 * N_SWEEP + N_RAND + N_RAND2 + 8;
  localparam int WATCHDOG_CYCLES = 40 * TOTAL_INSTR + 2 * RST_CYCLES;

  typedef struct packed {
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   wdata;
    logic [REG_AW-1:0] rs1;
    logic [XLEN-1:0]   rs1_rdata;
    logic [REG_AW-1:0] rs2;
    logic [XLEN-1:0]   rs2_rdata;
  } record_t;

  logic              clk_i;
  logic              rst_ni;
  logic              in_valid;
  logic [XLEN-1:0]   in_instr;
  logic              in_ready;
  logic              glitch_valid;
  logic [REG_AW-1:0] glitch_addr;
  logic [WORD_W-1:0] glitch_mask;
  logic              retire_valid;
  logic [REG_AW-1:0] retire_rd;
  logic [XLEN-1:0]   retire_wdata;
  logic [REG_AW-1:0] retire_rs1;
  logic [XLEN-1:0]   retire_rs1_rdata;
  logic [REG_AW-1:0] retire_rs2;
  logic [XLEN-1:0]   retire_rs2_rdata;
  logic              alert_major;

  // Reference model state kept in program order
  logic [XLEN-1:0] shadow [NUM_REGS];
  record_t         exp_q [$];
  logic [31:0]     lcg_state;
  int              issued;
  string           test_name;

  secdp_top #(.NUM_REGS(NUM_REGS)) u_dut (
    .clk_i, .rst_ni, .in_valid, .in_instr, .in_ready,
    .glitch_valid, .glitch_addr, .glitch_mask,
    .retire_valid, .retire_rd, .retire_wdata,
    .retire_rs1, .retire_rs1_rdata, .retire_rs2, .retire_rs2_rdata,
    .alert_major
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper LCG bits are the better random ones
  function automatic logic [REG_AW-1:0] draw_reg();
    logic [31:0] r;
    r = lcg_next();
    return r[31:27];
  endfunction

  function automatic logic [REG_AW-1:0] draw_nonzero_reg();
    logic [REG_AW-1:0] r;
    r = draw_reg();
    if (r == '0)
      r = 5'd1;
    return r;
  endfunction

  // One of the seven defined opcodes
  function automatic logic [3:0] draw_op();
    logic [31:0] r;
    logic [31:0] t;
    r = lcg_next();
    t = {16'd0, r[31:16]} % 32'd7;
    return t[3:0];
  endfunction

  // Mask with one or two set bits anywhere in the stored word
  function automatic logic [WORD_W-1:0] draw_mask();
    logic [31:0]       r;
    logic [WORD_W-1:0] mask;
    int                p1;
    int                p2;
    r    = lcg_next();
    p1   = int'({16'd0, r[15:0]}) % WORD_W;
    p2   = int'({16'd0, r[31:16]}) % WORD_W;
    mask = '0;
    mask[p1] = 1'b1;
    if (r[7])
      mask[p2] = 1'b1;
    return mask;
  endfunction

  function automatic logic [XLEN-1:0] make_instr(input logic [3:0] opc,
      input logic [REG_AW-1:0] rd, input logic [REG_AW-1:0] rs1,
      input logic [REG_AW-1:0] rs2, input logic [11:0] imm);
    return {opc, rd, rs1, rs2, 1'b0, imm};
  endfunction

  // Executes one instruction on the shadow registers and returns its record
  function automatic record_t model_exec(input logic [XLEN-1:0] instr);
    record_t           rec;
    logic [3:0]        opc;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic              use1;
    logic              use2;
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
    logic [XLEN-1:0]   res;
    opc  = instr[31:28];
    rd   = instr[27:23];
    rs1  = instr[22:18];
    rs2  = instr[17:13];
    use1 = (opc != OP_LUI);
    use2 = (opc != OP_ADDI) && (opc != OP_LUI);
    // Unused sources show up as address and data zero
    a = use1 ? shadow[rs1] : '0;
    b = use2 ? shadow[rs2] : '0;
    case (opc)
      OP_SUB:  res = a - b;
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_ADDI: res = a + {{20{instr[11]}}, instr[11:0]};
      OP_LUI:  res = {instr[11:0], 20'd0};
      default: res = a + b;
    endcase
    // Register 0 keeps reading zero
    if (rd != '0)
      shadow[rd] = res;
    rec.rd        = rd;
    rec.wdata     = res;
    rec.rs1       = use1 ? rs1 : '0;
    rec.rs1_rdata = a;
    rec.rs2       = use2 ? rs2 : '0;
    rec.rs2_rdata = b;
    return rec;
  endfunction

  task automatic stop_run();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic compare_record(input string name, input record_t exp_rec,
      input record_t act_rec);
    if (exp_rec !== act_rec) begin
      $display("[FAIL] %s expected rd=%0d wdata=%h rs1=%0d/%h rs2=%0d/%h", name,
               exp_rec.rd, exp_rec.wdata, exp_rec.rs1, exp_rec.rs1_rdata,
               exp_rec.rs2, exp_rec.rs2_rdata);
      $display("[FAIL] %s actual   rd=%0d wdata=%h rs1=%0d/%h rs2=%0d/%h", name,
               act_rec.rd, act_rec.wdata, act_rec.rs1, act_rec.rs1_rdata,
               act_rec.rs2, act_rec.rs2_rdata);
      stop_run();
    end
  endtask

  task automatic compare_alert(input string name, input logic exp_alert,
      input logic act_alert);
    if (exp_alert !== act_alert) begin
      $display("[FAIL] %s alert_major expected %b actual %b", name, exp_alert, act_alert);
      stop_run();
    end
  endtask

  // Offers one instruction and returns on the falling edge before it is accepted
  task automatic send(input logic [XLEN-1:0] instr, input logic expect_retire);
    int waited;
    waited = 0;
    @(negedge clk_i);
    in_valid = 1'b1;
    in_instr = instr;
    while (!in_ready) begin
      waited++;
      if (waited > 50) begin
        $display("in_ready stayed low for %0d cycles in test %s", waited, test_name);
        stop_run();
      end
      @(negedge clk_i);
    end
    if (expect_retire)
      exp_q.push_back(model_exec(instr));
    issued++;
  endtask

  task automatic hold_idle();
    @(negedge clk_i);
    in_valid = 1'b0;
  endtask

  // Waits until every accepted instruction has retired
  task automatic drain();
    int waited;
    waited = 0;
    hold_idle();
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
      waited++;
      if (waited > 100) begin
        $display("Pipeline did not drain in test %s, %0d retirements missing",
                 test_name, exp_q.size());
        stop_run();
      end
    end
    repeat (2) @(negedge clk_i);
  endtask

  task automatic inject(input logic [REG_AW-1:0] addr, input logic [WORD_W-1:0] mask);
    @(negedge clk_i);
    glitch_valid = 1'b1;
    glitch_addr  = addr;
    glitch_mask  = mask;
    @(negedge clk_i);
    glitch_valid = 1'b0;
  endtask

  // Holds reset for RST_CYCLES edges when called at time zero or on a falling edge
  task automatic apply_reset();
    int i;
    rst_ni       = 1'b0;
    in_valid     = 1'b0;
    glitch_valid = 1'b0;
    repeat (RST_CYCLES) @(negedge clk_i);
    if (in_ready || retire_valid) begin
      $display("[FAIL] %s in_ready/retire_valid expected 0/0 actual %b/%b during reset",
               test_name, in_ready, retire_valid);
      stop_run();
    end
    compare_alert("reset", 1'b0, alert_major);
    rst_ni = 1'b1;
    for (i = 0; i < NUM_REGS; i++)
      shadow[i] = '0;
    exp_q.delete();
  endtask

  // Every register is read once on each port and all of them must read zero
  task automatic sweep_reset_values();
    int i;
    test_name = "reset_values";
    for (i = 0; i < N_SWEEP; i++)
      send(make_instr(OP_ADD, 5'd0, i[4:0], i[4:0], 12'd0), 1'b1);
    drain();
    compare_alert(test_name, 1'b0, alert_major);
  endtask

  task automatic random_traffic(input int count);
    int                n;
    logic [31:0]       r;
    logic [REG_AW-1:0] prev_rd;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    test_name = "random_alu";
    prev_rd   = 5'd1;
    for (n = 0; n < count; n++) begin
      r   = lcg_next();
      rd  = draw_reg();
      rs1 = draw_reg();
      rs2 = draw_reg();
      // Chain on the last destination often so the interlock gets exercised
      if (r[1:0] != 2'b00)
        rs1 = prev_rd;
      if (r[2])
        rs2 = prev_rd;
      send(make_instr(draw_op(), rd, rs1, rs2, r[31:20]), 1'b1);
      if (r[5:3] == 3'd0)
        hold_idle();
      prev_rd = rd;
    end
    drain();
  endtask

  // Retirements are checked in order against the model queue
  always @(negedge clk_i) begin : retire_monitor
    record_t exp_rec;
    record_t act_rec;
    if (rst_ni && retire_valid) begin
      if (exp_q.size() == 0) begin
        $display("Retirement seen in test %s with no instruction outstanding", test_name);
        stop_run();
      end
      exp_rec            = exp_q.pop_front();
      act_rec.rd         = retire_rd;
      act_rec.wdata      = retire_wdata;
      act_rec.rs1        = retire_rs1;
      act_rec.rs1_rdata  = retire_rs1_rdata;
      act_rec.rs2        = retire_rs2;
      act_rec.rs2_rdata  = retire_rs2_rdata;
      compare_record(test_name, exp_rec, act_rec);
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles with %0d instructions issued, the run hung",
             WATCHDOG_CYCLES, issued);
    stop_run();
  end

  initial begin : main
    logic [REG_AW-1:0] r_bad;
    logic [31:0]       r;
    int                waited;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    in_valid     = 1'b0;
    in_instr     = '0;
    glitch_valid = 1'b0;
    glitch_addr  = '0;
    glitch_mask  = '0;
    lcg_state    = 32'hf743;
    issued       = 0;
    test_name    = "reset";
    apply_reset();
    sweep_reset_values();
    random_traffic(N_RAND);

    // Writes to register 0 retire with their value but leave it at zero
    test_name = "entry_zero";
    send(make_instr(OP_ADDI, 5'd0, 5'd0, 5'd0, 12'h5a5), 1'b1);
    send(make_instr(OP_ADD, 5'd7, 5'd0, 5'd0, 12'd0), 1'b1);
    drain();

    // Glitched register only in fields that ADDI and LUI ignore
    test_name = "unused_fault";
    r_bad = draw_nonzero_reg();
    inject(r_bad, draw_mask());
    r = lcg_next();
    send(make_instr(OP_ADDI, r_bad + 5'd2, r_bad + 5'd1, r_bad, r[11:0]), 1'b1);
    send(make_instr(OP_LUI, r_bad + 5'd2, r_bad, r_bad, r[23:12]), 1'b1);
    drain();
    compare_alert(test_name, 1'b0, alert_major);
    // A fresh write re-encodes the glitched entry
    send(make_instr(OP_LUI, r_bad, 5'd0, 5'd0, r[31:20]), 1'b1);
    drain();
    random_traffic(N_RAND2);

    // Glitched register read by the next instruction, which must not retire
    test_name = "used_fault";
    r_bad = draw_nonzero_reg();
    inject(r_bad, draw_mask());
    // The glitch alone raises nothing until an instruction uses the entry
    compare_alert(test_name, 1'b0, alert_major);
    r = lcg_next();
    if (r[0])
      send(make_instr(OP_XOR, 5'd3, r_bad, 5'd0, 12'd0), 1'b0);
    else
      send(make_instr(OP_SUB, 5'd3, 5'd0, r_bad, 12'd0), 1'b0);
    // An independent instruction right behind it issues as the alert rises and is dropped
    send(make_instr(OP_ADDI, 5'd4, 5'd0, 5'd0, 12'h001), 1'b0);
    hold_idle();
    waited = 0;
    while (!alert_major) begin
      @(negedge clk_i);
      waited++;
      if (waited > 20) begin
        $display("alert_major did not rise after a fault on a used operand");
        stop_run();
      end
    end
    // The stream keeps offering work while the alert must keep the input closed
    in_valid = 1'b1;
    in_instr = make_instr(OP_ADDI, 5'd4, 5'd0, 5'd0, 12'h001);
    repeat (10) begin
      @(negedge clk_i);
      if (in_ready) begin
        $display("[FAIL] %s in_ready expected 0 actual %b while the alert is held",
                 test_name, in_ready);
        stop_run();
      end
      compare_alert(test_name, 1'b1, alert_major);
    end
    apply_reset();
    sweep_reset_values();

    $display("TEST PASS");
    $finish;
  end

endmodule
